// ==== source/axi_pkg.sv ====
package axi_pkg;

    // ID bit that tags traffic from master port 1
    localparam int ROUTE_BIT = 1;

    // ****************************************
    // Encodings
    // ****************************************

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    // ****************************************
    // Read channels
    // ****************************************

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
        logic [3:0]  len;       // Beats minus one
        logic [2:0]  size;      // Log2 of bytes per beat
        axi_burst_e  burst;
        logic [1:0]  lock;
        logic [3:0]  cache;
        logic [2:0]  prot;
    } axi_ar_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] data;
        axi_resp_e   resp;
        logic        last;
    } axi_r_t;

endpackage

// ==== source/mem_pkg.sv ====
package mem_pkg;

    // One RAM word as wide as the AXI data bus
    typedef logic [31:0] word_t;

    // Full AXI byte address
    typedef logic [31:0] byte_addr_t;

    // Read slave states
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,     // Ready for a new request
        ST_READ = 2'd1,     // RAM read in flight
        ST_BEAT = 2'd2      // Beat on the R channel
    } rd_state_e;

endpackage

// ==== source/axi_rmux.sv ====
`timescale 1ns/1ps

module axi_rmux (
    // Master 0 for instruction fetch
    input  axi_pkg::axi_ar_t ar_0,
    input  logic             arvalid_0,
    output logic             arready_0,
    output axi_pkg::axi_r_t  r_0,
    output logic             rvalid_0,
    input  logic             rready_0,

    // Master 1 for data
    input  axi_pkg::axi_ar_t ar_1,
    input  logic             arvalid_1,
    output logic             arready_1,
    output axi_pkg::axi_r_t  r_1,
    output logic             rvalid_1,
    input  logic             rready_1,

    // Slave side
    output axi_pkg::axi_ar_t ar,
    output logic             arvalid,
    input  logic             arready,
    input  axi_pkg::axi_r_t  r,
    input  logic             rvalid,
    output logic             rready
);

    axi_pkg::axi_ar_t ar_1_tagged;
    axi_pkg::axi_r_t  r_ret;
    logic             to_port_1;

    // ****************************************
    // Address channel
    // ****************************************

    always_comb begin
        ar_1_tagged = ar_1;
        ar_1_tagged.id[axi_pkg::ROUTE_BIT] = 1'b1;    // Mark for the return path
    end

    // Port 0 wins whenever it requests
    assign ar        = arvalid_0 ? ar_0 : ar_1_tagged;
    assign arvalid   = arvalid_0 | arvalid_1;
    assign arready_0 = arready;
    assign arready_1 = arready & ~arvalid_0;         // Only when port 1 is the one forwarded

    // ****************************************
    // Read data channel
    // ****************************************

    assign to_port_1 = r.id[axi_pkg::ROUTE_BIT];

    always_comb begin
        r_ret = r;
        r_ret.id[axi_pkg::ROUTE_BIT] = 1'b0;
    end

    assign r_0 = r_ret;
    assign r_1 = r_ret;

    assign rvalid_0 = rvalid & ~to_port_1;
    assign rvalid_1 = rvalid & to_port_1;
    assign rready   = to_port_1 ? rready_1 : rready_0;

endmodule

// ==== source/axi_burst_rd.sv ====
`timescale 1ns/1ps

module axi_burst_rd #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  aclk,
    input  logic                  reset,

    // Read address channel
    input  axi_pkg::axi_ar_t      ar,
    input  logic                  arvalid,
    output logic                  arready,

    // Read data channel
    output axi_pkg::axi_r_t       r,
    output logic                  rvalid,
    input  logic                  rready,

    // RAM read port
    output logic [ADDR_WIDTH-1:0] ram_addr,
    input  mem_pkg::word_t        ram_rdata
);

    mem_pkg::rd_state_e  state;

    // Latched request
    logic [3:0]          id_q;
    logic [3:0]          len_q;
    logic [2:0]          size_q;
    axi_pkg::axi_burst_e burst_q;

    mem_pkg::byte_addr_t beat_addr;
    mem_pkg::byte_addr_t next_addr;
    mem_pkg::byte_addr_t beat_bytes;
    mem_pkg::byte_addr_t wrap_mask;
    logic [3:0]          beat_cnt;
    logic                last_beat;
    logic                in_range;
    logic                accept_ar;
    logic                accept_r;

    assign accept_ar = (state == mem_pkg::ST_IDLE) && arvalid;
    assign accept_r  = (state == mem_pkg::ST_BEAT) && rready;
    assign last_beat = beat_cnt == len_q;

    // ****************************************
    // Beat address generation
    // ****************************************

    assign beat_bytes = 32'd1 << size_q;

    // Window of (len+1) beats is a power of two for legal WRAP lengths
    assign wrap_mask = (({28'd0, len_q} + 32'd1) << size_q) - 32'd1;

    always_comb begin
        case (burst_q)
            axi_pkg::BURST_FIXED: next_addr = beat_addr;
            axi_pkg::BURST_WRAP: begin
                next_addr = (beat_addr & ~wrap_mask) | ((beat_addr + beat_bytes) & wrap_mask);
            end
            default: next_addr = beat_addr + beat_bytes;    // INCR and the reserved code
        endcase
    end

    // Word index must fit the RAM
    assign in_range = (beat_addr >> (ADDR_WIDTH + 2)) == '0;
    assign ram_addr = beat_addr[ADDR_WIDTH+1:2];

    // ****************************************
    // Control FSM
    // ****************************************

    always_ff @(posedge aclk) begin
        if (reset) begin
            state    <= mem_pkg::ST_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                mem_pkg::ST_IDLE: begin
                    if (arvalid) begin
                        state    <= mem_pkg::ST_READ;
                        beat_cnt <= '0;
                    end
                end
                mem_pkg::ST_READ: state <= mem_pkg::ST_BEAT;   // RAM registers the word
                mem_pkg::ST_BEAT: begin
                    if (rready) begin
                        if (last_beat) begin
                            state <= mem_pkg::ST_IDLE;
                        end else begin
                            state    <= mem_pkg::ST_READ;
                            beat_cnt <= beat_cnt + 4'd1;
                        end
                    end
                end
                default: state <= mem_pkg::ST_IDLE;
            endcase
        end
    end

    // Request fields and the running address
    always_ff @(posedge aclk) begin
        if (accept_ar) begin
            id_q      <= ar.id;
            len_q     <= ar.len;
            size_q    <= ar.size;
            burst_q   <= ar.burst;
            beat_addr <= ar.addr;
        end else if (accept_r && !last_beat) begin
            beat_addr <= next_addr;
        end
    end

    // ****************************************
    // Channel outputs
    // ****************************************

    assign arready = state == mem_pkg::ST_IDLE;
    assign rvalid  = state == mem_pkg::ST_BEAT;

    always_comb begin
        r.id   = id_q;
        r.data = in_range ? ram_rdata : '0;
        r.resp = in_range ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
        r.last = last_beat;
    end

endmodule

// ==== source/word_ram.sv ====
`timescale 1ns/1ps

module word_ram #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  aclk,

    // Preload write port
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] waddr,
    input  mem_pkg::word_t        wdata,

    // Read port with one cycle latency
    input  logic [ADDR_WIDTH-1:0] raddr,
    output mem_pkg::word_t        rdata
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    mem_pkg::word_t mem [DEPTH];

    always_ff @(posedge aclk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Old contents on a same-address read and write
    always_ff @(posedge aclk) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== source/axi_rd_fabric.sv ====
`timescale 1ns/1ps

module axi_rd_fabric #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  aclk,
    input  logic                  reset,

    // Master port 0 for instruction fetch
    input  axi_pkg::axi_ar_t      ar_0,
    input  logic                  arvalid_0,
    output logic                  arready_0,
    output axi_pkg::axi_r_t       r_0,
    output logic                  rvalid_0,
    input  logic                  rready_0,

    // Master port 1 for data
    input  axi_pkg::axi_ar_t      ar_1,
    input  logic                  arvalid_1,
    output logic                  arready_1,
    output axi_pkg::axi_r_t       r_1,
    output logic                  rvalid_1,
    input  logic                  rready_1,

    // Preload only while no burst is active
    input  logic                  init_we,
    input  logic [ADDR_WIDTH-1:0] init_addr,
    input  mem_pkg::word_t        init_data
);

    axi_pkg::axi_ar_t      mem_ar;
    logic                  mem_arvalid;
    logic                  mem_arready;
    axi_pkg::axi_r_t       mem_r;
    logic                  mem_rvalid;
    logic                  mem_rready;
    logic [ADDR_WIDTH-1:0] ram_addr;
    mem_pkg::word_t        ram_rdata;

    axi_rmux u_rmux (
        .ar_0      (ar_0),
        .arvalid_0 (arvalid_0),
        .arready_0 (arready_0),
        .r_0       (r_0),
        .rvalid_0  (rvalid_0),
        .rready_0  (rready_0),
        .ar_1      (ar_1),
        .arvalid_1 (arvalid_1),
        .arready_1 (arready_1),
        .r_1       (r_1),
        .rvalid_1  (rvalid_1),
        .rready_1  (rready_1),
        .ar        (mem_ar),
        .arvalid   (mem_arvalid),
        .arready   (mem_arready),
        .r         (mem_r),
        .rvalid    (mem_rvalid),
        .rready    (mem_rready)
    );

    axi_burst_rd #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_burst_rd (
        .aclk      (aclk),
        .reset     (reset),
        .ar        (mem_ar),
        .arvalid   (mem_arvalid),
        .arready   (mem_arready),
        .r         (mem_r),
        .rvalid    (mem_rvalid),
        .rready    (mem_rready),
        .ram_addr  (ram_addr),
        .ram_rdata (ram_rdata)
    );

    word_ram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ram (
        .aclk  (aclk),
        .we    (init_we),
        .waddr (init_addr),
        .wdata (init_data),
        .raddr (ram_addr),
        .rdata (ram_rdata)
    );

endmodule

// ==== tests/tb_axi_rd_fabric.sv ====
`timescale 1ns/1ps

module tb_axi_rd_fabric;

    localparam int ADDR_WIDTH = 8;
    localparam int MAX_TESTS  = 16;
    localparam int MAX_REQS   = 32;
    localparam int MAX_BEATS  = 256;

    logic                  aclk = 1'b0;
    logic                  reset;
    axi_pkg::axi_ar_t      ar_0;
    logic                  arvalid_0;
    logic                  arready_0;
    axi_pkg::axi_r_t       r_0;
    logic                  rvalid_0;
    logic                  rready_0;
    axi_pkg::axi_ar_t      ar_1;
    logic                  arvalid_1;
    logic                  arready_1;
    axi_pkg::axi_r_t       r_1;
    logic                  rvalid_1;
    logic                  rready_1;
    logic                  init_we;
    logic [ADDR_WIDTH-1:0] init_addr;
    mem_pkg::word_t        init_data;

    // Test data as read from the file
    string                 test_name [MAX_TESTS];
    int                    test_first [MAX_TESTS];     // First request of the test
    int                    test_reqs [MAX_TESTS];
    axi_pkg::axi_ar_t      req_ar [MAX_REQS];
    int                    req_port [MAX_REQS];
    int                    req_delay [MAX_REQS];
    int                    req_beat0 [MAX_REQS];       // Index of its first expected beat
    int                    raise_cyc [MAX_REQS];
    int                    first_cyc [MAX_REQS];
    int                    last_cyc [MAX_REQS];
    mem_pkg::word_t        exp_data [MAX_BEATS];
    logic [1:0]            exp_resp [MAX_BEATS];
    logic [ADDR_WIDTH-1:0] pre_addr [MAX_BEATS];
    mem_pkg::word_t        pre_data [MAX_BEATS];
    mem_pkg::word_t        model_mem [2**ADDR_WIDTH];  // Reference image of the RAM

    int                    num_tests;
    int                    num_reqs;
    int                    num_beats;
    int                    num_pre;
    int                    value_errors;
    int                    other_errors;
    int                    cycles;
    int                    cycle_limit = 200;
    integer                seed = 32'hf4d2;
    logic [1:0]            expect_r;                   // Port has a burst in flight

    axi_rd_fabric #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) dut (
        .aclk      (aclk),
        .reset     (reset),
        .ar_0      (ar_0),
        .arvalid_0 (arvalid_0),
        .arready_0 (arready_0),
        .r_0       (r_0),
        .rvalid_0  (rvalid_0),
        .rready_0  (rready_0),
        .ar_1      (ar_1),
        .arvalid_1 (arvalid_1),
        .arready_1 (arready_1),
        .r_1       (r_1),
        .rvalid_1  (rvalid_1),
        .rready_1  (rready_1),
        .init_we   (init_we),
        .init_addr (init_addr),
        .init_data (init_data)
    );

    always #4 aclk = ~aclk;

    // Random back-pressure stalls about one cycle in four
    always @(posedge aclk) begin
        if (reset) begin
            rready_0 <= 1'b0;
            rready_1 <= 1'b0;
        end else begin
            rready_0 <= ($random(seed) & 3) != 0;
            rready_1 <= ($random(seed) & 3) != 0;
        end
    end

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the bursts did not complete", cycles);
            $display("Errors: %0d value, %0d other", value_errors, other_errors + 1);
            $display("Testbench failed");
            $finish;
        end
    end

    // A beat on a port with nothing outstanding is misrouted
    always @(negedge aclk) begin
        if (!reset && rvalid_0 && !expect_r[0]) begin
            $display("Unexpected rvalid on port 0 at cycle %0d", cycles);
            other_errors++;
        end
        if (!reset && rvalid_1 && !expect_r[1]) begin
            $display("Unexpected rvalid on port 1 at cycle %0d", cycles);
            other_errors++;
        end
    end

    // ****************************************
    // Reference model and checks
    // ****************************************

    function automatic logic [31:0] beat_address(axi_pkg::axi_ar_t a, int k);
        logic [31:0] step;
        logic [31:0] window;
        step   = 32'd1 << a.size;
        window = (a.len + 32'd1) * step;
        case (a.burst)
            axi_pkg::BURST_FIXED: beat_address = a.addr;
            axi_pkg::BURST_WRAP: begin
                beat_address = (a.addr & ~(window - 1)) + ((a.addr + k * step) % window);
            end
            default:              beat_address = a.addr + k * step;
        endcase
    endfunction

    function automatic string beat_text(axi_pkg::axi_r_t b);
        beat_text = $sformatf("id=%h data=%h resp=%0d last=%b", b.id, b.data, b.resp, b.last);
    endfunction

    task automatic check_r(string name, axi_pkg::axi_r_t exp, axi_pkg::axi_r_t act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error %s: expected %s, actual %s", name,
                     beat_text(exp), beat_text(act));
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            value_errors++;
            $display("** Error %s: expected %0d beats, actual %0d", name, exp, act);
        end
    endtask

    // Cross-check every expected beat against the preload image
    task automatic cross_check_beats();
        axi_pkg::axi_ar_t a;
        logic [31:0]      addr;
        mem_pkg::word_t   w;
        logic [1:0]       rsp;
        for (int i = 0; i < num_reqs; i++) begin
            a = req_ar[i];
            for (int k = 0; k <= a.len; k++) begin
                addr = beat_address(a, k);
                if ((addr >> (ADDR_WIDTH + 2)) != 0) begin
                    w   = '0;
                    rsp = 2'd2;     // SLVERR
                end else begin
                    w   = model_mem[addr[ADDR_WIDTH+1:2]];
                    rsp = 2'd0;
                end
                if (exp_data[req_beat0[i] + k] !== w || exp_resp[req_beat0[i] + k] !== rsp) begin
                    $display("Test data of request %0d beat %0d disagrees with the model", i, k);
                    other_errors++;
                end
            end
        end
    endtask

    // ****************************************
    // Stimulus
    // ****************************************

    task automatic load_test_file();
        int               fd;
        int               n;
        string            line;
        string            name;
        logic [31:0]      f [7];
        axi_pkg::axi_ar_t a;
        fd = $fopen("tests/axi_rd_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file tests/axi_rd_testdata.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 0) begin
                    case (line.getc(0))
                        "P": begin
                            n = $sscanf(line, "P %h %h", f[0], f[1]);
                            pre_addr[num_pre] = f[0][ADDR_WIDTH-1:0];
                            pre_data[num_pre] = f[1];
                            model_mem[f[0][ADDR_WIDTH-1:0]] = f[1];
                            num_pre++;
                        end
                        "T": begin
                            n = $sscanf(line, "T %s", name);
                            test_name[num_tests]  = name;
                            test_first[num_tests] = num_reqs;
                            num_tests++;
                        end
                        "R": begin
                            n = $sscanf(line, "R %h %h %h %h %h %h %h",
                                        f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                            a       = '0;
                            a.id    = f[1][3:0];
                            a.addr  = f[2];
                            a.len   = f[3][3:0];
                            a.size  = f[4][2:0];
                            a.burst = axi_pkg::axi_burst_e'(f[5][1:0]);
                            req_ar[num_reqs]    = a;
                            req_port[num_reqs]  = f[0];
                            req_delay[num_reqs] = f[6];
                            req_beat0[num_reqs] = num_beats;
                            test_reqs[num_tests-1]++;
                            num_reqs++;
                        end
                        "B": begin
                            n = $sscanf(line, "B %h %h", f[0], f[1]);
                            exp_data[num_beats] = f[0];
                            exp_resp[num_beats] = f[1][1:0];
                            num_beats++;
                        end
                        default: ;  // Comment or blank line
                    endcase
                end
            end
            $fclose(fd);
            cycle_limit = 20 * num_beats + 200;
        end
    endtask

    task automatic preload_ram();
        for (int i = 0; i < num_pre; i++) begin
            @(posedge aclk);
            init_we   <= 1'b1;
            init_addr <= pre_addr[i];
            init_data <= pre_data[i];
        end
        @(posedge aclk);
        init_we <= 1'b0;
    endtask

    // Issue this port's requests of one test and collect their beats
    task automatic run_port(int port, int t);
        axi_pkg::axi_ar_t a;
        axi_pkg::axi_r_t  exp;
        axi_pkg::axi_r_t  act;
        int               idx;
        int               beats;
        logic             got_last;
        for (int i = 0; i < test_reqs[t]; i++) begin
            idx = test_first[t] + i;
            a   = req_ar[idx];
            if (req_port[idx] == port) begin
                repeat (req_delay[idx]) @(posedge aclk);
                @(posedge aclk);
                if (port == 0) begin
                    ar_0      <= a;
                    arvalid_0 <= 1'b1;
                end else begin
                    ar_1      <= a;
                    arvalid_1 <= 1'b1;
                end
                @(negedge aclk);
                raise_cyc[idx] = cycles;
                while (!((port == 0) ? arready_0 : arready_1)) @(negedge aclk);
                @(posedge aclk);    // Address handshake
                if (port == 0) begin
                    arvalid_0 <= 1'b0;
                end else begin
                    arvalid_1 <= 1'b0;
                end
                expect_r[port] = 1'b1;
                beats    = 0;
                got_last = 1'b0;
                while (!got_last && beats <= a.len) begin
                    @(negedge aclk);
                    act = (port == 0) ? r_0 : r_1;
                    if ((port == 0) ? (rvalid_0 && rready_0) : (rvalid_1 && rready_1)) begin
                        if (port == 0) begin
                            exp.id = a.id;
                        end else begin
                            exp.id = a.id & ~(4'b1 << axi_pkg::ROUTE_BIT);
                        end
                        exp.data = exp_data[req_beat0[idx] + beats];
                        exp.resp = axi_pkg::axi_resp_e'(exp_resp[req_beat0[idx] + beats]);
                        exp.last = beats == a.len;
                        if (beats == 0) begin
                            first_cyc[idx] = cycles;
                        end
                        last_cyc[idx] = cycles;
                        check_r($sformatf("%s beat %0d", test_name[t], beats), exp, act);
                        got_last = act.last;
                        beats++;
                    end
                end
                @(posedge aclk);
                expect_r[port] = 1'b0;
                check_count(test_name[t], a.len + 1, beats);
                if (!got_last) begin
                    $display("%s: the final beat came without rlast", test_name[t]);
                    other_errors++;
                end
            end
        end
    endtask

    // Requests raised together must be served port 0 first
    task automatic check_order(int t);
        int a;
        int b;
        for (int i = 0; i < test_reqs[t]; i++) begin
            for (int j = 0; j < test_reqs[t]; j++) begin
                a = test_first[t] + i;
                b = test_first[t] + j;
                if (req_port[a] == 0 && req_port[b] == 1 && raise_cyc[a] == raise_cyc[b]
                    && last_cyc[a] >= first_cyc[b]) begin
                    $display("%s: port 1 data came before the port 0 burst ended", test_name[t]);
                    other_errors++;
                end
            end
        end
    endtask

    initial begin
        reset     = 1'b1;
        ar_0      = '0;
        arvalid_0 = 1'b0;
        rready_0  = 1'b0;
        ar_1      = '0;
        arvalid_1 = 1'b0;
        rready_1  = 1'b0;
        init_we   = 1'b0;
        init_addr = '0;
        init_data = '0;
        expect_r  = '0;
        load_test_file();
        cross_check_beats();
        repeat (2) @(posedge aclk);
        reset <= 1'b0;
        preload_ram();
        for (int t = 0; t < num_tests; t++) begin
            fork
                run_port(0, t);
                run_port(1, t);
            join
            check_order(t);
        end
        repeat (4) @(posedge aclk);     // Room for stray beats
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== tests/axi_rd_testdata.txt ====
# P word_addr data | T test_name | R port id addr len size burst delay (burst 0 FIXED 1 INCR 2 WRAP)
# B data resp, one line per expected beat after its R line (resp 0 OKAY 2 SLVERR), all hex
P 04 c0de0004
P 05 c0de0005
P 06 c0de0006
P 07 c0de0007
P 10 5eed0010
P 20 0badf020
P 21 0badf021
P 22 0badf022
P 23 0badf023
P fe e00000fe
P ff e00000ff

T incr_port0
R 0 5 00000010 3 2 1 0
B c0de0004 0
B c0de0005 0
B c0de0006 0
B c0de0007 0

T fixed_port1
R 1 3 00000040 2 2 0 0
B 5eed0010 0
B 5eed0010 0
B 5eed0010 0

T wrap_port1
R 1 9 00000088 3 2 2 0
B 0badf022 0
B 0badf023 0
B 0badf020 0
B 0badf021 0

T narrow_port1
R 1 6 00000080 3 1 1 3
B 0badf020 0
B 0badf020 0
B 0badf021 0
B 0badf021 0

T both_ports
R 0 1 00000010 1 2 1 0
B c0de0004 0
B c0de0005 0
R 1 4 00000018 1 2 1 0
B c0de0006 0
B c0de0007 0

T slverr_port0
R 0 c 000003f8 3 2 1 0
B e00000fe 0
B e00000ff 0
B 00000000 2
B 00000000 2

// ==== axi_rd_fabric.f ====
source/axi_pkg.sv
source/mem_pkg.sv
source/axi_rmux.sv
source/axi_burst_rd.sv
source/word_ram.sv
source/axi_rd_fabric.sv
tests/tb_axi_rd_fabric.sv

// ==== Bender.yml ====
package:
  name: axi_rd_fabric

sources:
  - files:
      - source/axi_pkg.sv
      - source/mem_pkg.sv
      - source/axi_rmux.sv
      - source/axi_burst_rd.sv
      - source/word_ram.sv
      - source/axi_rd_fabric.sv
  - target: test
    files:
      - tests/tb_axi_rd_fabric.sv
